//--- include/dm_csrs_defines.svh
// ----------------------------------------------------------
// Debug module register block constants
// ----------------------------------------------------------

`ifndef DM_CSRS_DEFINES_SVH
`define DM_CSRS_DEFINES_SVH

// harts behind this debug module
`define DM_NR_HARTS 4

// hartsello only, hartselhi is not implemented
`define DM_HARTSEL_W 10

// DMI widths
`define DM_DATA_W 32
`define DM_ADDR_W 7

// abstract data registers
`define DM_DATA_COUNT 2

// debug spec 0.13
`define DM_VERSION 4'd2

`endif

//--- design/dm_csrs_pkg.sv
// ----------------------------------------------------------
// Debug module register types
// ----------------------------------------------------------

`include "dm_csrs_defines.svh"

package dm_csrs_pkg;

  // DMI operation field
  typedef enum logic [1:0] {
    DtmNop   = 2'd0,
    DtmRead  = 2'd1,
    DtmWrite = 2'd2
  } dtm_op_e;

  // register map as seen on the DMI
  typedef enum logic [`DM_ADDR_W-1:0] {
    Data0      = 7'h04,
    Data1      = 7'h05,
    DMControl  = 7'h10,
    DMStatus   = 7'h11,
    AbstractCS = 7'h16,
    Command    = 7'h17,
    HaltSum0   = 7'h40,
    CsrNone    = 7'h7F
  } dm_csr_e;

  // abstractcs.cmderr encoding
  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrBusy         = 3'd1,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4,
    CmdErrBus          = 3'd5,
    CmdErrOther        = 3'd7
  } cmderr_e;

endpackage : dm_csrs_pkg

//--- design/dmi_req_decode.sv
// ----------------------------------------------------------
// DMI request decode stage
// ----------------------------------------------------------

`timescale 1ns/100ps

`include "dm_csrs_defines.svh"

module dmi_req_decode import dm_csrs_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  dmi_req_valid_i,
  input  logic                  dmi_req_ready_i,
  input  logic [`DM_ADDR_W-1:0] dmi_req_addr_i,
  input  dtm_op_e               dmi_req_op_i,
  input  logic [`DM_DATA_W-1:0] dmi_req_data_i,
  output logic                  dec_valid_o,
  output logic                  dec_write_o,
  output dm_csr_e               dec_csr_o,
  output logic [`DM_DATA_W-1:0] dec_wdata_o
);

  logic    req_accept;
  dm_csr_e csr_raw;
  dm_csr_e csr_d;

  assign req_accept = dmi_req_valid_i & dmi_req_ready_i;
  assign csr_raw    = dm_csr_e'(dmi_req_addr_i);

  // unmapped addresses and nops collapse to a read of CsrNone
  always_comb begin
    case (csr_raw)
      Data0, Data1, DMControl, DMStatus,
      AbstractCS, Command, HaltSum0: csr_d = csr_raw;
      default:                       csr_d = CsrNone;
    endcase
    if (dmi_req_op_i == DtmNop) begin
      csr_d = CsrNone;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o <= 1'b0;
      dec_write_o <= 1'b0;
      dec_csr_o   <= CsrNone;
    end else begin
      dec_valid_o <= req_accept;
      if (req_accept) begin
        dec_write_o <= (dmi_req_op_i == DtmWrite);
        dec_csr_o   <= csr_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      dec_wdata_o <= dmi_req_data_i;
    end
  end

  // op 3 is reserved by the DTM and must never reach the DM
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_accept |-> (dmi_req_op_i != 2'd3));

endmodule : dmi_req_decode

//--- design/dm_ctrl_regs.sv
// ----------------------------------------------------------
// dmcontrol, dmstatus and haltsum0
// ----------------------------------------------------------

`timescale 1ns/100ps

`include "dm_csrs_defines.svh"

module dm_ctrl_regs import dm_csrs_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    dec_valid_i,
  input  logic                    dec_write_i,
  input  dm_csr_e                 dec_csr_i,
  input  logic [`DM_DATA_W-1:0]   dec_wdata_i,
  input  logic [`DM_NR_HARTS-1:0] halted_i,
  input  logic [`DM_NR_HARTS-1:0] unavailable_i,
  input  logic [`DM_NR_HARTS-1:0] resumeack_i,
  output logic [`DM_DATA_W-1:0]   rdata_o,
  output logic                    dmactive_o,
  output logic                    ndmreset_o,
  output logic [`DM_NR_HARTS-1:0] haltreq_o,
  output logic [`DM_NR_HARTS-1:0] resumereq_o,
  output logic                    clear_resumeack_o
);

  localparam int unsigned HartIdxW = $clog2(`DM_NR_HARTS);

  logic                     dmactive_q;
  logic                     ndmreset_q;
  logic                     haltreq_q;
  logic                     resumereq_q;
  logic                     resumereq_d;
  logic [`DM_HARTSEL_W-1:0] hartsel_q;
  logic                     wr_dmcontrol;
  logic                     hart_exists;
  logic [HartIdxW-1:0]      sel_idx;
  logic                     sel_halted;
  logic                     sel_unavail;
  logic                     sel_resumeack;
  logic [`DM_DATA_W-1:0]    dmcontrol_rd;
  logic [`DM_DATA_W-1:0]    dmstatus_rd;
  logic [`DM_DATA_W-1:0]    haltsum0_rd;

  assign wr_dmcontrol  = dec_valid_i & dec_write_i & (dec_csr_i == DMControl);
  assign hart_exists   = (hartsel_q < `DM_HARTSEL_W'(`DM_NR_HARTS));
  assign sel_idx       = hartsel_q[HartIdxW-1:0];
  assign sel_halted    = halted_i[sel_idx];
  assign sel_unavail   = unavailable_i[sel_idx];
  assign sel_resumeack = hart_exists & resumeack_i[sel_idx];

  // resumereq drops once the selected hart acknowledges
  always_comb begin
    resumereq_d = wr_dmcontrol ? dec_wdata_i[30] : resumereq_q;
    if (resumereq_q && sel_resumeack) begin
      resumereq_d = 1'b0;
    end
  end

  // rising edge of resumereq lets the hart drop its old ack
  assign clear_resumeack_o = wr_dmcontrol & dmactive_q & ~resumereq_q & dec_wdata_i[30];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmactive_q  <= 1'b0;
      ndmreset_q  <= 1'b0;
      hartsel_q   <= '0;
      haltreq_q   <= 1'b0;
      resumereq_q <= 1'b0;
    end else if (!dmactive_q) begin
      // soft reset, only dmactive can be written
      ndmreset_q  <= 1'b0;
      hartsel_q   <= '0;
      haltreq_q   <= 1'b0;
      resumereq_q <= 1'b0;
      if (wr_dmcontrol) begin
        dmactive_q <= dec_wdata_i[0];
      end
    end else begin
      if (wr_dmcontrol) begin
        dmactive_q <= dec_wdata_i[0];
        ndmreset_q <= dec_wdata_i[1];
        hartsel_q  <= dec_wdata_i[25:16];
        haltreq_q  <= dec_wdata_i[31];
      end
      resumereq_q <= resumereq_d;
    end
  end

  // ----------------------------------------------------------
  // hart request routing
  // ----------------------------------------------------------
  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (hart_exists) begin
      haltreq_o[sel_idx]   = haltreq_q;
      resumereq_o[sel_idx] = resumereq_q;
    end
  end

  assign dmactive_o = dmactive_q;
  assign ndmreset_o = ndmreset_q;

  // ----------------------------------------------------------
  // read words
  // ----------------------------------------------------------
  always_comb begin
    dmcontrol_rd        = '0;
    dmcontrol_rd[31]    = haltreq_q;
    dmcontrol_rd[30]    = resumereq_q;
    dmcontrol_rd[25:16] = hartsel_q;
    dmcontrol_rd[1]     = ndmreset_q;
    dmcontrol_rd[0]     = dmactive_q;
  end

  // hart fields read zero for a nonexistent hart
  always_comb begin
    dmstatus_rd        = '0;
    dmstatus_rd[3:0]   = `DM_VERSION;
    dmstatus_rd[7]     = 1'b1;
    dmstatus_rd[9:8]   = {2{hart_exists & sel_halted & ~sel_unavail}};
    dmstatus_rd[11:10] = {2{hart_exists & ~sel_halted & ~sel_unavail}};
    dmstatus_rd[13:12] = {2{hart_exists & sel_unavail}};
    dmstatus_rd[15:14] = {2{~hart_exists}};
    dmstatus_rd[17:16] = {2{sel_resumeack}};
  end

  assign haltsum0_rd = (hartsel_q[`DM_HARTSEL_W-1:5] == '0) ? `DM_DATA_W'(halted_i) : '0;

  always_comb begin
    case (dec_csr_i)
      DMControl: rdata_o = dmcontrol_rd;
      DMStatus:  rdata_o = dmstatus_rd;
      HaltSum0:  rdata_o = haltsum0_rd;
      default:   rdata_o = '0;
    endcase
  end

  // at most one hart is asked to halt at any time
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(haltreq_o));

endmodule : dm_ctrl_regs

//--- design/dm_abstract_regs.sv
// ----------------------------------------------------------
// Abstract command registers
// ----------------------------------------------------------

`timescale 1ns/100ps

`include "dm_csrs_defines.svh"

module dm_abstract_regs import dm_csrs_pkg::*; (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     dec_valid_i,
  input  logic                                     dec_write_i,
  input  dm_csr_e                                  dec_csr_i,
  input  logic [`DM_DATA_W-1:0]                    dec_wdata_i,
  input  logic                                     dmactive_i,
  input  logic                                     cmdbusy_i,
  input  logic                                     cmderror_valid_i,
  input  cmderr_e                                  cmderror_i,
  input  logic                                     data_valid_i,
  input  logic [`DM_DATA_COUNT-1:0][`DM_DATA_W-1:0] data_i,
  output logic [`DM_DATA_W-1:0]                    rdata_o,
  output logic                                     cmd_valid_o,
  output logic [`DM_DATA_W-1:0]                    cmd_o,
  output logic [`DM_DATA_COUNT-1:0][`DM_DATA_W-1:0] data_o
);

  localparam int unsigned DataIdxW = $clog2(`DM_DATA_COUNT);
  localparam logic [`DM_ADDR_W-1:0] DataLast = `DM_ADDR_W'(Data0 + `DM_DATA_COUNT - 1);

  cmderr_e                                   cmderr_q;
  cmderr_e                                   cmderr_d;
  logic [`DM_DATA_W-1:0]                     command_q;
  logic [`DM_DATA_W-1:0]                     command_d;
  logic                                      cmd_valid_q;
  logic                                      cmd_valid_d;
  logic [`DM_DATA_COUNT-1:0][`DM_DATA_W-1:0] data_q;
  logic [`DM_DATA_COUNT-1:0][`DM_DATA_W-1:0] data_d;
  logic                                      is_data;
  logic [DataIdxW-1:0]                       data_idx;
  logic                                      busy_access;
  logic [`DM_DATA_W-1:0]                     abstractcs_rd;

  assign is_data  = (dec_csr_i >= Data0) && (dec_csr_i <= DataLast);
  assign data_idx = DataIdxW'(dec_csr_i - Data0);

  // accesses that collide with a running command
  assign busy_access = is_data || (dec_csr_i == Command) ||
                       (dec_write_i && (dec_csr_i == AbstractCS));

  always_comb begin
    cmderr_d    = cmderr_q;
    command_d   = command_q;
    data_d      = data_q;
    cmd_valid_d = 1'b0;

    if (dec_valid_i) begin
      if (cmdbusy_i && busy_access) begin
        if (cmderr_q == CmdErrNone) begin
          cmderr_d = CmdErrBusy;
        end
      end else if (dec_write_i) begin
        if (is_data) begin
          data_d[data_idx] = dec_wdata_i;
        end else if (dec_csr_i == Command) begin
          command_d   = dec_wdata_i;
          cmd_valid_d = 1'b1;
        end else if (dec_csr_i == AbstractCS) begin
          // cmderr is write-1-to-clear
          cmderr_d = cmderr_e'(cmderr_q & ~dec_wdata_i[10:8]);
        end
      end
    end

    // hart side wins over the DMI
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= CmdErrNone;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      data_q      <= '0;
    end else if (!dmactive_i) begin
      cmderr_q    <= CmdErrNone;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      data_q      <= '0;
    end else begin
      cmderr_q    <= cmderr_d;
      command_q   <= command_d;
      cmd_valid_q <= cmd_valid_d;
      data_q      <= data_d;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;

  // ----------------------------------------------------------
  // read words
  // ----------------------------------------------------------
  always_comb begin
    abstractcs_rd       = '0;
    abstractcs_rd[3:0]  = 4'(`DM_DATA_COUNT);
    abstractcs_rd[10:8] = cmderr_q;
    abstractcs_rd[12]   = cmdbusy_i;
  end

  // command is write-only and reads zero
  always_comb begin
    if (is_data) begin
      rdata_o = data_q[data_idx];
    end else if (dec_csr_i == AbstractCS) begin
      rdata_o = abstractcs_rd;
    end else begin
      rdata_o = '0;
    end
  end

  // each command write is a single strobe
  assert property (@(posedge clk_i) disable iff (!rst_ni) cmd_valid_o |=> !cmd_valid_o);

endmodule : dm_abstract_regs

//--- design/dmi_resp_queue.sv
// ----------------------------------------------------------
// DMI response queue
// ----------------------------------------------------------

`timescale 1ns/100ps

`include "dm_csrs_defines.svh"

module dmi_resp_queue import dm_csrs_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  logic [`DM_DATA_W-1:0] push_data_i,
  input  logic                  dec_valid_i,
  output logic                  dmi_req_ready_o,
  output logic                  dmi_resp_valid_o,
  output logic [`DM_DATA_W-1:0] dmi_resp_data_o,
  input  logic                  dmi_resp_ready_i
);

  logic [`DM_DATA_W-1:0] mem_q [2];
  logic [1:0]            count_q;
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;
  logic                  pop;

  assign pop              = dmi_resp_valid_o & dmi_resp_ready_i;
  assign dmi_resp_valid_o = (count_q != 2'd0);
  assign dmi_resp_data_o  = mem_q[rd_ptr_q];

  // credit counts the entry still in decode
  assign dmi_req_ready_o = (({1'b0, count_q} + {2'b00, dec_valid_i}) < 3'd2);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q  <= 2'd0;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + 2'(push_i) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // request credit must keep a slot free for every decoded request
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> (count_q < 2'd2));

endmodule : dmi_resp_queue

//--- design/dm_csrs_top.sv
// ----------------------------------------------------------
// Debug module registers top
// ----------------------------------------------------------

`timescale 1ns/100ps

`include "dm_csrs_defines.svh"

module dm_csrs_top (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // DMI
  input  logic                                     dmi_req_valid_i,
  output logic                                     dmi_req_ready_o,
  input  logic [`DM_ADDR_W-1:0]                    dmi_req_addr_i,
  input  dm_csrs_pkg::dtm_op_e                     dmi_req_op_i,
  input  logic [`DM_DATA_W-1:0]                    dmi_req_data_i,
  output logic                                     dmi_resp_valid_o,
  input  logic                                     dmi_resp_ready_i,
  output logic [`DM_DATA_W-1:0]                    dmi_resp_data_o,
  // hart status and control
  output logic                                     ndmreset_o,
  output logic                                     dmactive_o,
  input  logic [`DM_NR_HARTS-1:0]                  halted_i,
  input  logic [`DM_NR_HARTS-1:0]                  unavailable_i,
  input  logic [`DM_NR_HARTS-1:0]                  resumeack_i,
  output logic [`DM_NR_HARTS-1:0]                  haltreq_o,
  output logic [`DM_NR_HARTS-1:0]                  resumereq_o,
  output logic                                     clear_resumeack_o,
  // abstract commands
  output logic                                     cmd_valid_o,
  output logic [`DM_DATA_W-1:0]                    cmd_o,
  input  logic                                     cmderror_valid_i,
  input  dm_csrs_pkg::cmderr_e                     cmderror_i,
  input  logic                                     cmdbusy_i,
  output logic [`DM_DATA_COUNT-1:0][`DM_DATA_W-1:0] data_o,
  input  logic [`DM_DATA_COUNT-1:0][`DM_DATA_W-1:0] data_i,
  input  logic                                     data_valid_i
);

  logic                  dec_valid;
  logic                  dec_write;
  dm_csrs_pkg::dm_csr_e  dec_csr;
  logic [`DM_DATA_W-1:0] dec_wdata;
  logic [`DM_DATA_W-1:0] ctrl_rdata;
  logic [`DM_DATA_W-1:0] abs_rdata;
  logic [`DM_DATA_W-1:0] push_data;

  // unowned addresses read zero in each stage
  assign push_data = ctrl_rdata | abs_rdata;

  dmi_req_decode dmi_req_decode_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .dmi_req_valid_i (dmi_req_valid_i),
    .dmi_req_ready_i (dmi_req_ready_o),
    .dmi_req_addr_i  (dmi_req_addr_i),
    .dmi_req_op_i    (dmi_req_op_i),
    .dmi_req_data_i  (dmi_req_data_i),
    .dec_valid_o     (dec_valid),
    .dec_write_o     (dec_write),
    .dec_csr_o       (dec_csr),
    .dec_wdata_o     (dec_wdata)
  );

  dm_ctrl_regs dm_ctrl_regs_inst (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dec_valid_i       (dec_valid),
    .dec_write_i       (dec_write),
    .dec_csr_i         (dec_csr),
    .dec_wdata_i       (dec_wdata),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .rdata_o           (ctrl_rdata),
    .dmactive_o        (dmactive_o),
    .ndmreset_o        (ndmreset_o),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o)
  );

  dm_abstract_regs dm_abstract_regs_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dec_valid_i      (dec_valid),
    .dec_write_i      (dec_write),
    .dec_csr_i        (dec_csr),
    .dec_wdata_i      (dec_wdata),
    .dmactive_i       (dmactive_o),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .rdata_o          (abs_rdata),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o)
  );

  dmi_resp_queue dmi_resp_queue_inst (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .push_i           (dec_valid),
    .push_data_i      (push_data),
    .dec_valid_i      (dec_valid),
    .dmi_req_ready_o  (dmi_req_ready_o),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_data_o  (dmi_resp_data_o),
    .dmi_resp_ready_i (dmi_resp_ready_i)
  );

endmodule : dm_csrs_top

//--- verification/dm_csrs_tb.sv
// ----------------------------------------------------------
// Debug module registers testbench
// ----------------------------------------------------------

`timescale 1ns/100ps

`include "dm_csrs_defines.svh"

module dm_csrs_tb import dm_csrs_pkg::*; ();

  localparam int RESET_CYCLES = 10;

  logic                                      clk_i = 1'b0;
  logic                                      rst_ni;
  logic                                      dmi_req_valid_i;
  logic                                      dmi_req_ready_o;
  logic [`DM_ADDR_W-1:0]                     dmi_req_addr_i;
  dtm_op_e                                   dmi_req_op_i;
  logic [`DM_DATA_W-1:0]                     dmi_req_data_i;
  logic                                      dmi_resp_valid_o;
  logic                                      dmi_resp_ready_i;
  logic [`DM_DATA_W-1:0]                     dmi_resp_data_o;
  logic                                      ndmreset_o;
  logic                                      dmactive_o;
  logic [`DM_NR_HARTS-1:0]                   halted_i;
  logic [`DM_NR_HARTS-1:0]                   unavailable_i;
  logic [`DM_NR_HARTS-1:0]                   resumeack_i;
  logic [`DM_NR_HARTS-1:0]                   haltreq_o;
  logic [`DM_NR_HARTS-1:0]                   resumereq_o;
  logic                                      clear_resumeack_o;
  logic                                      cmd_valid_o;
  logic [`DM_DATA_W-1:0]                     cmd_o;
  logic                                      cmderror_valid_i;
  cmderr_e                                   cmderror_i;
  logic                                      cmdbusy_i;
  logic [`DM_DATA_COUNT-1:0][`DM_DATA_W-1:0] data_o;
  logic [`DM_DATA_COUNT-1:0][`DM_DATA_W-1:0] data_i;
  logic                                      data_valid_i;

  // reference model state
  logic                                      m_dmactive;
  logic                                      m_ndmreset;
  logic                                      m_haltreq;
  logic                                      m_resumereq;
  logic [`DM_HARTSEL_W-1:0]                  m_hartsel;
  logic [2:0]                                m_cmderr;
  logic [`DM_DATA_W-1:0]                     m_command;
  logic [`DM_DATA_COUNT-1:0][`DM_DATA_W-1:0] m_data;

  logic [`DM_DATA_W-1:0] exp_q [$];
  int                    errors = 0;
  int                    checks = 0;
  int                    req_cnt = 0;
  int                    resp_cnt = 0;
  int                    cmd_pulses = 0;
  int                    clr_pulses = 0;
  int                    test_err_base = 0;

  dm_csrs_top dm_csrs_top_inst (.*);

  always #5 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic logic [31:0] ref_read(input logic [6:0] addr, input dtm_op_e op);
    logic [31:0] word;
    logic        exists;
    logic [1:0]  sel;
    word   = '0;
    exists = (m_hartsel < 10'd4);
    sel    = m_hartsel[1:0];
    if (op != DtmNop) begin
      case (addr)
        Data0:     word = m_data[0];
        Data1:     word = m_data[1];
        DMControl: word = {m_haltreq, m_resumereq, 4'b0, m_hartsel, 14'b0, m_ndmreset, m_dmactive};
        DMStatus: begin
          word[3:0] = 4'd2;
          word[7]   = 1'b1;
          if (exists) begin
            word[9:8]   = {2{halted_i[sel] & ~unavailable_i[sel]}};
            word[11:10] = {2{~halted_i[sel] & ~unavailable_i[sel]}};
            word[13:12] = {2{unavailable_i[sel]}};
            word[17:16] = {2{resumeack_i[sel]}};
          end else begin
            word[15:14] = 2'b11;
          end
        end
        AbstractCS: word = {19'b0, cmdbusy_i, 1'b0, m_cmderr, 8'd2};
        HaltSum0:   word = (m_hartsel[9:5] == 5'd0) ? {28'b0, halted_i} : 32'd0;
        default:    word = '0;
      endcase
    end
    return word;
  endfunction

  task automatic clear_model();
    m_dmactive  = 1'b0;
    m_ndmreset  = 1'b0;
    m_haltreq   = 1'b0;
    m_resumereq = 1'b0;
    m_hartsel   = '0;
    m_cmderr    = 3'd0;
    m_command   = '0;
    m_data      = '0;
  endtask

  task automatic model_apply(input logic [6:0] addr, input dtm_op_e op, input logic [31:0] w);
    logic wr;
    logic busy_hit;
    wr       = (op == DtmWrite);
    busy_hit = cmdbusy_i && (op != DtmNop) &&
               (addr == Data0 || addr == Data1 || addr == Command || (wr && addr == AbstractCS));
    if (!m_dmactive) begin
      if (wr && addr == DMControl) begin
        m_dmactive = w[0];
      end
    end else if (wr && addr == DMControl) begin
      if (!w[0]) begin
        // deactivation soft resets everything
        clear_model();
      end else begin
        m_ndmreset  = w[1];
        m_hartsel   = w[25:16];
        m_haltreq   = w[31];
        m_resumereq = w[30];
      end
    end else if (busy_hit) begin
      if (m_cmderr == 3'd0) begin
        m_cmderr = 3'd1;
      end
    end else if (wr) begin
      case (addr)
        Data0:      m_data[0] = w;
        Data1:      m_data[1] = w;
        Command:    m_command = w;
        AbstractCS: m_cmderr  = m_cmderr & ~w[10:8];
        default:    ;
      endcase
    end
  endtask

  // ----------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------
  task automatic dmi_request(input logic [6:0] addr, input dtm_op_e op, input logic [31:0] w);
    @(negedge clk_i);
    dmi_req_valid_i = 1'b1;
    dmi_req_addr_i  = addr;
    dmi_req_op_i    = op;
    dmi_req_data_i  = w;
    while (!dmi_req_ready_o) begin
      @(negedge clk_i);
    end
    // accepted at the coming rising edge
    exp_q.push_back(ref_read(addr, op));
    model_apply(addr, op, w);
    req_cnt++;
    @(negedge clk_i);
    dmi_req_valid_i = 1'b0;
  endtask

  task automatic write_reg(input logic [6:0] addr, input logic [31:0] w);
    dmi_request(addr, DtmWrite, w);
  endtask

  task automatic read_reg(input logic [6:0] addr);
    dmi_request(addr, DtmRead, 32'd0);
  endtask

  task automatic wait_responses();
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
  endtask

  function automatic logic [31:0] make_dmcontrol(input logic halt, input logic resume,
                                                 input logic [9:0] hs);
    return {halt, resume, 4'b0, hs, 15'b0, 1'b1};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %-24s %s (%0d errors)", num, name,
             (errors == test_err_base) ? "ok" : "FAILED", errors - test_err_base);
    test_err_base = errors;
  endtask

  // ----------------------------------------------------------
  // response compare and pulse monitors
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    logic [31:0] exp;
    if (rst_ni && dmi_resp_valid_o && dmi_resp_ready_i) begin
      resp_cnt++;
      checks++;
      if (exp_q.size() == 0) begin
        $display("response arrived with no request outstanding");
        errors++;
      end else begin
        exp = exp_q.pop_front();
        assert (dmi_resp_data_o === exp) else begin
          $display("** Error: dmi_resp_data_o = %h, expected %h", dmi_resp_data_o, exp);
          errors++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    if (cmd_valid_o === 1'b1) begin
      cmd_pulses++;
    end
    if (clear_resumeack_o === 1'b1) begin
      clr_pulses++;
    end
  end

  // budget grows with every accepted request
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < RESET_CYCLES + 20 * (req_cnt + 1)) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("watchdog expired after %0d cycles with %0d requests", cycles, req_cnt);
    $display("Test failures found");
    $finish;
  end

  // ----------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------
  initial begin : main
    logic [9:0]  hs;
    logic [3:0]  onehot;
    logic [31:0] word;
    logic [2:0]  err_codes [5];
    int          pulses;
    err_codes = '{3'd2, 3'd3, 3'd4, 3'd5, 3'd7};
    void'($urandom(82));
    rst_ni           = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_addr_i   = '0;
    dmi_req_op_i     = DtmNop;
    dmi_req_data_i   = '0;
    dmi_resp_ready_i = 1'b1;
    halted_i         = '0;
    unavailable_i    = '0;
    resumeack_i      = '0;
    cmderror_valid_i = 1'b0;
    cmderror_i       = CmdErrNone;
    cmdbusy_i        = 1'b0;
    data_i           = '0;
    data_valid_i     = 1'b0;
    clear_model();
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;

    // 1: dmcontrol fields and soft reset
    write_reg(DMControl, 32'hFFFF_FFFE);
    write_reg(Data0, 32'h1234_5678);
    read_reg(DMControl);
    read_reg(Data0);
    read_reg(7'h20);
    dmi_request(DMControl, DtmNop, 32'd0);
    wait_responses();
    check_value("dmactive_o", 32'(dmactive_o), 32'd0);
    write_reg(DMControl, 32'h0000_0001);
    write_reg(DMControl, 32'hFFFF_FFFF);
    read_reg(DMControl);
    wait_responses();
    check_value("dmactive_o", 32'(dmactive_o), 32'd1);
    check_value("ndmreset_o", 32'(ndmreset_o), 32'd1);
    write_reg(DMControl, 32'h0000_0000);
    wait_responses();
    read_reg(DMControl);
    write_reg(DMControl, 32'h0000_0001);
    wait_responses();
    check_value("dmactive_o", 32'(dmactive_o), 32'd1);
    check_value("ndmreset_o", 32'(ndmreset_o), 32'd0);
    report_test(1, "dmcontrol");

    // 2: hart request routing
    for (int i = 0; i < 4; i++) begin
      hs     = 10'($urandom % 4);
      onehot = 4'(1 << hs[1:0]);
      pulses = clr_pulses;
      write_reg(DMControl, make_dmcontrol(1'b1, 1'b1, hs));
      wait_responses();
      check_value("clear_resumeack_o pulses", 32'(clr_pulses - pulses), 32'd1);
      check_value("haltreq_o", 32'(haltreq_o), 32'(onehot));
      check_value("resumereq_o", 32'(resumereq_o), 32'(onehot));
      @(negedge clk_i);
      resumeack_i = onehot;
      m_resumereq = 1'b0;
      repeat (2) @(negedge clk_i);
      resumeack_i = '0;
      read_reg(DMControl);
      wait_responses();
      check_value("resumereq_o", 32'(resumereq_o), 32'd0);
    end
    hs = 10'd4 + 10'($urandom % 1020);
    write_reg(DMControl, make_dmcontrol(1'b1, 1'b1, hs));
    read_reg(DMControl);
    wait_responses();
    check_value("haltreq_o", 32'(haltreq_o), 32'd0);
    check_value("resumereq_o", 32'(resumereq_o), 32'd0);
    report_test(2, "hart requests");

    // 3: dmstatus and haltsum0 over random hart states
    for (int i = 0; i < 8; i++) begin
      if (i < 4) begin
        hs = 10'(i);
      end else if (i < 6) begin
        hs = 10'd4 + 10'($urandom % 28);
      end else begin
        hs = 10'($urandom % 1024);
      end
      @(negedge clk_i);
      halted_i      = 4'($urandom);
      unavailable_i = 4'($urandom);
      resumeack_i   = 4'($urandom);
      write_reg(DMControl, make_dmcontrol(1'b0, 1'b0, hs));
      read_reg(DMStatus);
      read_reg(HaltSum0);
      wait_responses();
    end
    resumeack_i = '0;
    report_test(3, "dmstatus haltsum0");

    // 4: abstract command and cmderr
    word   = $urandom;
    pulses = cmd_pulses;
    write_reg(Command, word);
    read_reg(AbstractCS);
    wait_responses();
    check_value("cmd_valid_o pulses", 32'(cmd_pulses - pulses), 32'd1);
    check_value("cmd_o", cmd_o, word);
    cmdbusy_i = 1'b1;
    pulses    = cmd_pulses;
    write_reg(Command, ~word);
    read_reg(AbstractCS);
    wait_responses();
    check_value("cmd_valid_o pulses", 32'(cmd_pulses - pulses), 32'd0);
    check_value("cmd_o", cmd_o, word);
    cmdbusy_i = 1'b0;
    write_reg(AbstractCS, 32'h0000_0700);
    read_reg(AbstractCS);
    wait_responses();
    @(negedge clk_i);
    cmderror_valid_i = 1'b1;
    cmderror_i       = cmderr_e'(err_codes[$urandom % 5]);
    m_cmderr         = cmderror_i;
    @(negedge clk_i);
    cmderror_valid_i = 1'b0;
    read_reg(AbstractCS);
    write_reg(AbstractCS, 32'h0000_0700);
    read_reg(AbstractCS);
    wait_responses();
    report_test(4, "abstract command");

    // 5: data registers
    write_reg(Data0, $urandom);
    write_reg(Data1, $urandom);
    read_reg(Data0);
    read_reg(Data1);
    wait_responses();
    cmdbusy_i = 1'b1;
    write_reg(Data0, $urandom);
    write_reg(Data1, $urandom);
    read_reg(Data1);
    read_reg(AbstractCS);
    wait_responses();
    check_value("data_o[0]", data_o[0], m_data[0]);
    cmdbusy_i = 1'b0;
    write_reg(AbstractCS, 32'h0000_0700);
    @(negedge clk_i);
    data_i       = {$urandom, $urandom};
    data_valid_i = 1'b1;
    m_data       = data_i;
    @(negedge clk_i);
    data_valid_i = 1'b0;
    read_reg(Data0);
    read_reg(Data1);
    wait_responses();
    check_value("data_o[0]", data_o[0], m_data[0]);
    check_value("data_o[1]", data_o[1], m_data[1]);
    report_test(5, "data registers");

    // 6: response back-pressure
    @(negedge clk_i);
    dmi_resp_ready_i = 1'b0;
    read_reg(Data0);
    read_reg(Data1);
    repeat (2) @(negedge clk_i);
    check_value("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'd0);
    check_value("dmi_resp_valid_o", 32'(dmi_resp_valid_o), 32'd1);
    dmi_resp_ready_i = 1'b1;
    read_reg(DMControl);
    read_reg(DMStatus);
    read_reg(AbstractCS);
    wait_responses();
    // queue must be empty once every expected response is taken
    check_value("dmi_resp_valid_o", 32'(dmi_resp_valid_o), 32'd0);
    check_value("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'd1);
    report_test(6, "back-pressure");

    $display("checks %0d, errors %0d, requests %0d, responses %0d",
             checks, errors, req_cnt, resp_cnt);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule : dm_csrs_tb

//--- dm_csrs.f
+incdir+include
design/dm_csrs_pkg.sv
design/dmi_req_decode.sv
design/dm_ctrl_regs.sv
design/dm_abstract_regs.sv
design/dmi_resp_queue.sv
design/dm_csrs_top.sv
verification/dm_csrs_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the debug module register testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dm_csrs_tb -f dm_csrs.f \
  -o dm_csrs_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/dm_csrs_sim > sim.log 2>&1
cat sim.log

grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
